// ==== build.f ====
+incdir+.
sq_pkg.sv
store_dispatch.sv
store_queue.sv
store_mem_port.sv
store_subsystem.sv
sq_asserts.sv
tb_store_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# builds the store subsystem testbench with Verilator and runs it
# exit status is zero only when the pass line appears in the output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_store_subsystem -o sim_store_subsystem

output=$(./obj_dir/sim_store_subsystem 2>&1 || true)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "Done: no errors"

// ==== sq_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// protocol checks bound into the store subsystem top
// drain_valid is internal, so the module relies on the bind scope
// back-to-back commits would hold drain_valid for two cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module sq_asserts (
	input  logic                clock,
	input  logic                reset,
	input  logic                store_valid,
	input  sq_pkg::store_req_t  store_req,
	input  logic                commit_valid,
	input  logic [1:0]          full,
	input  logic                commit_done,
	input  logic                drain_valid
);

	// rename has no stall path into dispatch
	no_store_when_full: assert property (@(posedge clock) disable iff (reset)
		store_valid |-> !full[store_req.thread])
		else $error("store strobed to a full thread partition");

	// every done pulse answers a commit strobe one edge earlier
	done_needs_commit: assert property (@(posedge clock) disable iff (reset)
		commit_done |-> $past(commit_valid))
		else $error("commit_done high without a preceding commit strobe");

	drain_single_cycle: assert property (@(posedge clock) disable iff (reset)
		drain_valid |=> !drain_valid)
		else $error("drain_valid held for more than one cycle");

endmodule

bind store_subsystem sq_asserts asserts_i (
	.clock        (clock),
	.reset        (reset),
	.store_valid  (store_valid),
	.store_req    (store_req),
	.commit_valid (commit_valid),
	.full         (full),
	.commit_done  (commit_done),
	.drain_valid  (drain_valid)
);

// ==== sq_config.svh ====
//////////////////////////////////////////////////////////////////////
// sizing for the store queue subsystem
// SQ_DEPTH and MEM_WORDS must be powers of two
// PRF tags live in the low PRF_TAG_W bits of a waiting operand
//////////////////////////////////////////////////////////////////////

`ifndef SQ_CONFIG_SVH
`define SQ_CONFIG_SVH

// entries in each thread partition
`define SQ_DEPTH 8

// ROB index carried by every store
`define ROB_IDX_W 5

// physical register tag width, as seen on the CDB
`define PRF_TAG_W 6

// 64-bit data memory words, indexed by address bits above bit 2
`define MEM_WORDS 64

`endif

// ==== sq_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared store queue types and the CDB wakeup helpers
// an operand with ready low holds its awaited tag in the low bits
//////////////////////////////////////////////////////////////////////

`include "sq_config.svh"

package sq_pkg;

	typedef struct packed {
		logic [63:0] value;		// data, or tag while waiting
		logic        ready;
	} sq_operand_t;

	// store as sent by rename
	typedef struct packed {
		logic                   thread;
		sq_operand_t            base;
		logic [63:0]            offset;
		sq_operand_t            data;
		logic [`ROB_IDX_W-1:0]  rob_idx;
	} store_req_t;

	typedef struct packed {
		logic                   thread;
		sq_operand_t            base;
		logic [63:0]            offset;
		sq_operand_t            data;
		logic [`ROB_IDX_W-1:0]  rob_idx;
		logic [63:0]            addr;		// only meaningful once base is ready
	} sq_entry_t;

	typedef struct packed {
		logic [63:0]            value;
		logic [`PRF_TAG_W-1:0]  tag;
	} cdb_t;

	typedef struct packed {
		logic                   thread;
		logic [`ROB_IDX_W-1:0]  rob_idx;
	} commit_t;

	typedef struct packed {
		logic [63:0] addr;
		logic [63:0] data;
	} mem_store_t;

	// picks up a broadcast value if this operand waits on its tag
	function automatic sq_operand_t wake_operand(sq_operand_t op, logic cdb_valid, cdb_t cdb);
		sq_operand_t woken;
		woken = op;
		if (!op.ready && cdb_valid && op.value[`PRF_TAG_W-1:0] == cdb.tag) begin
			woken.value = cdb.value;
			woken.ready = 1'b1;
		end
		return woken;
	endfunction

	// wakes both operands, then forms the address once base is known
	function automatic sq_entry_t settle_entry(sq_entry_t e, logic cdb_valid, cdb_t cdb);
		sq_entry_t settled;
		settled      = e;
		settled.base = wake_operand(e.base, cdb_valid, cdb);
		settled.data = wake_operand(e.data, cdb_valid, cdb);
		if (settled.base.ready)
			settled.addr = settled.base.value + e.offset;
		return settled;
	endfunction

endpackage

// ==== store_dispatch.sv ====
//////////////////////////////////////////////////////////////////////
// one-stage store dispatch: rename store in, queue entry out
// a CDB hit in the rename cycle is folded into the registered entry
// no back-pressure, rename must not send to a full partition
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module store_dispatch (
	input  logic                clock,
	input  logic                reset,
	input  logic                store_valid,
	input  sq_pkg::store_req_t  store_req,
	input  logic                cdb_valid,
	input  sq_pkg::cdb_t        cdb,
	output logic                entry_valid,
	output sq_pkg::sq_entry_t   entry
);
	import sq_pkg::*;

	sq_entry_t raw_entry;		// rename fields mapped onto an entry
	sq_entry_t woken_entry;		// after same-cycle wakeup and address

	//////////////////////////////////////////////////////////////////////
	// entry formation
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		raw_entry.thread  = store_req.thread;
		raw_entry.base    = store_req.base;
		raw_entry.offset  = store_req.offset;
		raw_entry.data    = store_req.data;
		raw_entry.rob_idx = store_req.rob_idx;
		raw_entry.addr    = '0;		// filled in below when base is ready
	end

	// catches a tag broadcast in the same cycle the store arrives,
	// otherwise that wakeup would be lost between rename and the queue
	assign woken_entry = settle_entry(raw_entry, cdb_valid, cdb);

	//////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= 1'b0;
		end else begin
			entry_valid <= store_valid;		// one-cycle strobe follows the input
		end
	end

	always_ff @(posedge clock) begin
		if (store_valid) begin
			entry <= woken_entry;
		end
	end

endmodule

// ==== store_mem_port.sv ====
//////////////////////////////////////////////////////////////////////
// small data memory behind the store queue
// one write per drain strobe, taken at the following clock edge
// loads are combinational, only address bits above bit 2 select a word
// address bits above the word index are ignored, so addresses alias
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "sq_config.svh"

module store_mem_port (
	input  logic                clock,
	input  logic                reset,
	input  logic                drain_valid,
	input  sq_pkg::mem_store_t  drain,
	input  logic [63:0]         load_addr,
	output logic [63:0]         load_data
);
	localparam int IDX_W = $clog2(`MEM_WORDS);

	logic [63:0]       words [`MEM_WORDS];
	logic [IDX_W-1:0]  write_idx;
	logic [IDX_W-1:0]  read_idx;

	//////////////////////////////////////////////////////////////////////
	// word selection
	//////////////////////////////////////////////////////////////////////

	assign write_idx = drain.addr[IDX_W+2:3];	// 8-byte words
	assign read_idx  = load_addr[IDX_W+2:3];

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	// whole array clears on reset so loads start from zero
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `MEM_WORDS; i++) begin
				words[i] <= '0;
			end
		end else if (drain_valid) begin
			words[write_idx] <= drain.data;
		end
	end

	// new store data shows up right after the write edge
	assign load_data = words[read_idx];

endmodule

// ==== store_queue.sv ====
//////////////////////////////////////////////////////////////////////
// two-thread store queue, one circular partition per thread
// pointers carry a wrap bit so full and empty are told apart
// commit must name the head store by ROB index, others are ignored
// mispredict rolls the thread tail back to its head after commit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "sq_config.svh"

module store_queue (
	input  logic                clock,
	input  logic                reset,
	input  logic                entry_valid,
	input  sq_pkg::sq_entry_t   entry,
	input  logic                cdb_valid,
	input  sq_pkg::cdb_t        cdb,
	input  logic                commit_valid,
	input  sq_pkg::commit_t     commit,
	input  logic [1:0]          mispredict,
	output logic [1:0]          head_ready,
	output logic [1:0]          full,
	output logic                commit_done,
	output logic                commit_done_thread,
	output logic                drain_valid,
	output sq_pkg::mem_store_t  drain
);
	import sq_pkg::*;

	localparam int PTR_W = $clog2(`SQ_DEPTH);

	sq_entry_t       slots [2][`SQ_DEPTH];	// [thread][slot]
	logic [PTR_W:0]  head [2];				// msb is the wrap bit
	logic [PTR_W:0]  tail [2];
	logic [PTR_W:0]  head_next [2];
	sq_entry_t       head_entry [2];
	logic [1:0]      empty;
	sq_entry_t       commit_entry;
	logic            commit_hit;
	logic            accept;

	//////////////////////////////////////////////////////////////////////
	// partition status
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int t = 0; t < 2; t++) begin
			head_entry[t] = slots[t][head[t][PTR_W-1:0]];
			empty[t]      = (head[t] == tail[t]);
			// same slot, opposite lap
			full[t]       = (head[t][PTR_W-1:0] == tail[t][PTR_W-1:0]) &&
							(head[t][PTR_W] != tail[t][PTR_W]);
			head_ready[t] = !empty[t] && head_entry[t].base.ready &&
							head_entry[t].data.ready;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// commit and allocate decisions
	//////////////////////////////////////////////////////////////////////

	assign commit_entry = head_entry[commit.thread];

	// drain only a complete head whose ROB index matches
	assign commit_hit = commit_valid && head_ready[commit.thread] &&
						(commit_entry.rob_idx == commit.rob_idx);

	// a flushing thread drops its incoming store
	assign accept = entry_valid && !mispredict[entry.thread] && !full[entry.thread];

	always_comb begin
		for (int t = 0; t < 2; t++) begin
			head_next[t] = head[t];
			if (commit_hit && commit.thread == 1'(t))
				head_next[t] = head[t] + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// pointers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int t = 0; t < 2; t++) begin
				head[t] <= '0;
				tail[t] <= '0;
			end
		end else begin
			for (int t = 0; t < 2; t++) begin
				head[t] <= head_next[t];
				if (mispredict[t])
					tail[t] <= head_next[t];		// same-cycle commit still counts
				else if (accept && entry.thread == 1'(t))
					tail[t] <= tail[t] + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// entry storage with CDB wakeup
	//////////////////////////////////////////////////////////////////////

	// every slot listens, empty ones too, which is harmless
	always_ff @(posedge clock) begin
		for (int t = 0; t < 2; t++) begin
			for (int i = 0; i < `SQ_DEPTH; i++) begin
				slots[t][i] <= settle_entry(slots[t][i], cdb_valid, cdb);
			end
		end
		// new entry also sees the broadcast of its arrival cycle
		if (accept) begin
			slots[entry.thread][tail[entry.thread][PTR_W-1:0]] <=
				settle_entry(entry, cdb_valid, cdb);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// drain to memory and commit status
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_done        <= 1'b0;
			commit_done_thread <= 1'b0;
			drain_valid        <= 1'b0;
		end else begin
			commit_done <= commit_hit;
			drain_valid <= commit_hit;
			if (commit_hit)
				commit_done_thread <= commit.thread;
		end
	end

	always_ff @(posedge clock) begin
		if (commit_hit) begin
			drain.addr <= commit_entry.addr;
			drain.data <= commit_entry.data.value;
		end
	end

endmodule

// ==== store_subsystem.sv ====
//////////////////////////////////////////////////////////////////////
// store path top: dispatch, store queue, data memory
// every strobe is single-cycle with no back-pressure
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module store_subsystem (
	input  logic                clock,
	input  logic                reset,
	input  logic                store_valid,
	input  sq_pkg::store_req_t  store_req,
	input  logic                cdb_valid,
	input  sq_pkg::cdb_t        cdb,
	input  logic                commit_valid,
	input  sq_pkg::commit_t     commit,
	input  logic [1:0]          mispredict,
	input  logic [63:0]         load_addr,
	output logic [63:0]         load_data,
	output logic [1:0]          head_ready,
	output logic [1:0]          full,
	output logic                commit_done,
	output logic                commit_done_thread
);
	import sq_pkg::*;

	logic        entry_valid;
	sq_entry_t   entry;			// dispatch to queue
	logic        drain_valid;
	mem_store_t  drain;			// queue to memory

	store_dispatch dispatch_i (
		.clock       (clock),
		.reset       (reset),
		.store_valid (store_valid),
		.store_req   (store_req),
		.cdb_valid   (cdb_valid),
		.cdb         (cdb),
		.entry_valid (entry_valid),
		.entry       (entry)
	);

	store_queue queue_i (
		.clock              (clock),
		.reset              (reset),
		.entry_valid        (entry_valid),
		.entry              (entry),
		.cdb_valid          (cdb_valid),
		.cdb                (cdb),
		.commit_valid       (commit_valid),
		.commit             (commit),
		.mispredict         (mispredict),
		.head_ready         (head_ready),
		.full               (full),
		.commit_done        (commit_done),
		.commit_done_thread (commit_done_thread),
		.drain_valid        (drain_valid),
		.drain              (drain)
	);

	store_mem_port mem_i (
		.clock       (clock),
		.reset       (reset),
		.drain_valid (drain_valid),
		.drain       (drain),
		.load_addr   (load_addr),
		.load_data   (load_data)
	);

endmodule

// ==== tb_store_subsystem.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the store queue subsystem
// a cycle model of dispatch, queue and memory predicts every output
// outputs are compared at the falling edge, inputs change 1 ns after rise
// stimulus never sends a store to a full thread partition
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "sq_config.svh"

module tb_store_subsystem;
	import sq_pkg::*;

	localparam int IDX_W  = $clog2(`MEM_WORDS);
	localparam int IDX_HI = IDX_W + 2;
	// reset, five directed tests, random phase, drain, memory sweep
	localparam int TEST_CYCLES = 5 + 20 + 30 + 20 + 40 + 20 + 300 + 400 + 70;

	logic                  clock = 1'b0;
	logic                  reset;
	logic                  store_valid;
	store_req_t            store_req;
	logic                  cdb_valid;
	cdb_t                  cdb;
	logic                  commit_valid;
	commit_t               commit;
	logic [1:0]            mispredict;
	logic [63:0]           load_addr;
	logic [63:0]           load_data;
	logic [1:0]            head_ready;
	logic [1:0]            full;
	logic                  commit_done;
	logic                  commit_done_thread;

	sq_entry_t             model_q [2][$];		// queued stores per thread
	sq_entry_t             pend;				// dispatch register
	logic                  pend_valid;
	logic                  drain_pend;
	logic [63:0]           drain_addr;
	logic [63:0]           drain_data;
	logic                  exp_done;
	logic                  exp_done_thread;
	logic [63:0]           model_mem [`MEM_WORDS];
	logic [31:0]           lfsr = 32'hfac4;
	logic [`PRF_TAG_W-1:0] tag_q [$];			// tags still to broadcast
	logic [`ROB_IDX_W-1:0] rob_next [2];
	logic                  prev_commit;
	int                    errors;
	int                    errors_at_start;
	int                    tests_passed;
	int                    tests_failed;

	store_subsystem dut_i (.*);

	always #10 clock = ~clock;

	// taps 32 22 2 1, one step per bit taken
	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[62:0], fb};
		end
		return r;
	endfunction

	// a waiting operand takes the broadcast value when its tag matches
	function automatic sq_entry_t model_wake(sq_entry_t e, logic hit_valid, cdb_t c);
		if (hit_valid && !e.base.ready && e.base.value[`PRF_TAG_W-1:0] == c.tag)
			e.base = '{value: c.value, ready: 1'b1};
		if (hit_valid && !e.data.ready && e.data.value[`PRF_TAG_W-1:0] == c.tag)
			e.data = '{value: c.value, ready: 1'b1};
		if (e.base.ready)
			e.addr = e.base.value + e.offset;
		return e;
	endfunction

	function automatic logic head_complete(int t);
		return model_q[t].size() > 0 && model_q[t][0].base.ready &&
			model_q[t][0].data.ready;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference model, one update per rising edge
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin : model_step
		logic      hit;
		sq_entry_t head;
		hit  = 1'b0;
		head = '0;
		if (commit_valid && model_q[commit.thread].size() > 0) begin
			head = model_q[commit.thread][0];
			hit  = head.base.ready && head.data.ready && head.rob_idx == commit.rob_idx;
		end
		if (reset) begin
			model_q[0].delete();
			model_q[1].delete();
			pend_valid = 1'b0;
			drain_pend = 1'b0;
			exp_done   = 1'b0;
			for (int i = 0; i < `MEM_WORDS; i++)
				model_mem[i] = '0;
		end else begin
			if (drain_pend)
				model_mem[drain_addr[IDX_HI:3]] = drain_data;	// write lags the drain
			for (int t = 0; t < 2; t++)
				for (int i = 0; i < model_q[t].size(); i++)
					model_q[t][i] = model_wake(model_q[t][i], cdb_valid, cdb);
			drain_pend = hit;
			exp_done   = hit;
			if (hit) begin
				exp_done_thread = commit.thread;
				drain_addr      = head.addr;
				drain_data      = head.data.value;
				void'(model_q[commit.thread].pop_front());
			end
			for (int t = 0; t < 2; t++)
				if (mispredict[t])
					model_q[t].delete();		// after the commit pop
			if (pend_valid && !mispredict[pend.thread] &&
					model_q[pend.thread].size() < `SQ_DEPTH)
				model_q[pend.thread].push_back(model_wake(pend, cdb_valid, cdb));
			pend_valid = store_valid;
			pend = '{store_req.thread, store_req.base, store_req.offset, store_req.data,
				store_req.rob_idx, 64'd0};
			pend = model_wake(pend, cdb_valid, cdb);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output checks
	//////////////////////////////////////////////////////////////////////

	task automatic flag_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
		errors++;
		$display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
	endtask

	task automatic note_problem(string what);
		errors++;
		$display("ERROR t=%0t %s", $time, what);
	endtask

	always @(negedge clock) begin : output_checks
		logic [1:0]  exp_ready;
		logic [1:0]  exp_full;
		logic [63:0] exp_load;
		if (!reset) begin
			for (int t = 0; t < 2; t++) begin
				exp_ready[t] = head_complete(t);
				exp_full[t]  = model_q[t].size() == `SQ_DEPTH;
			end
			exp_load = model_mem[load_addr[IDX_HI:3]];
			assert (head_ready == exp_ready)
				else flag_mismatch("head_ready", 64'(exp_ready), 64'(head_ready));
			assert (full == exp_full)
				else flag_mismatch("full", 64'(exp_full), 64'(full));
			assert (commit_done == exp_done)
				else flag_mismatch("commit_done", 64'(exp_done), 64'(commit_done));
			assert (!exp_done || commit_done_thread == exp_done_thread)
				else flag_mismatch("commit_done_thread", 64'(exp_done_thread),
					64'(commit_done_thread));
			assert (load_data == exp_load)
				else flag_mismatch("load_data", exp_load, load_data);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clock);
		#1;
		prev_commit  = commit_valid;
		store_valid  = 1'b0;
		cdb_valid    = 1'b0;
		commit_valid = 1'b0;
		mispredict   = 2'b00;
	endtask

	task automatic idle(int n);
		repeat (n) next_cycle();
	endtask

	// waiting operands carry their tag in the low bits
	task automatic drive_store(logic thread, logic base_rdy, logic data_rdy);
		store_valid           = 1'b1;
		store_req.thread      = thread;
		store_req.base.ready  = base_rdy;
		store_req.data.ready  = data_rdy;
		store_req.offset      = rand_bits(12);
		store_req.rob_idx     = rob_next[thread];
		rob_next[thread]      = rob_next[thread] + 1'b1;
		if (base_rdy) begin
			store_req.base.value = rand_bits(64);
			load_addr            = store_req.base.value + store_req.offset;
		end else begin
			store_req.base.value = rand_bits(`PRF_TAG_W);
			tag_q.push_back(store_req.base.value[`PRF_TAG_W-1:0]);
		end
		if (data_rdy) begin
			store_req.data.value = rand_bits(64);
		end else begin
			store_req.data.value = rand_bits(`PRF_TAG_W);
			tag_q.push_back(store_req.data.value[`PRF_TAG_W-1:0]);
		end
	endtask

	task automatic drive_cdb();
		if (tag_q.size() > 0) begin
			cdb_valid = 1'b1;
			cdb.tag   = tag_q.pop_front();		// oldest waiting tag
			cdb.value = rand_bits(64);
		end
	endtask

	task automatic drive_commit(logic thread, logic wrong_idx);
		commit_valid   = 1'b1;
		commit.thread  = thread;
		commit.rob_idx = '0;
		if (model_q[thread].size() > 0)
			commit.rob_idx = model_q[thread][0].rob_idx;
		if (wrong_idx)
			commit.rob_idx = commit.rob_idx + 1'b1;
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		do begin
			next_cycle();
			waited++;
		end while (commit_done !== 1'b1 && waited < 8);
		if (commit_done !== 1'b1)
			note_problem("commit_done did not rise after a matching commit");
	endtask

	// one extra cycle lets the memory write land before the next step
	task automatic commit_head(logic thread);
		next_cycle();
		drive_commit(thread, 1'b0);
		wait_done();
		next_cycle();
	endtask

	task automatic start_test();
		errors_at_start = errors;
	endtask

	task automatic finish_test(string name);
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d failed checks", name, errors - errors_at_start);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	initial begin : main
		logic                  thr;
		int                    waited;
		logic [`ROB_IDX_W-1:0] flushed_rob;
		reset        = 1'b1;
		store_valid  = 1'b0;
		store_req    = '0;
		cdb_valid    = 1'b0;
		cdb          = '0;
		commit_valid = 1'b0;
		commit       = '0;
		mispredict   = 2'b00;
		load_addr    = '0;
		prev_commit  = 1'b0;
		rob_next[0]  = '0;
		rob_next[1]  = '0;
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;

		start_test();
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			drive_store(1'b0, 1'b1, 1'b1);
		end
		idle(2);
		for (int i = 0; i < 4; i++) begin
			load_addr = model_q[0][0].addr;		// watch the word being written
			commit_head(1'b0);
		end
		finish_test("in-order commit");

		start_test();
		next_cycle();
		drive_store(1'b0, 1'b0, 1'b0);
		idle(3);
		drive_cdb();		// base tag
		idle(2);
		drive_cdb();		// data tag
		idle(2);
		commit_head(1'b0);
		next_cycle();
		drive_store(1'b0, 1'b1, 1'b0);
		drive_cdb();		// data tag in its own dispatch cycle
		idle(2);
		commit_head(1'b0);
		finish_test("cdb wakeup");

		start_test();
		next_cycle();
		drive_store(1'b0, 1'b1, 1'b0);
		idle(2);
		drive_commit(1'b0, 1'b0);		// head still waits on data
		idle(2);
		drive_cdb();
		idle(2);
		drive_commit(1'b0, 1'b1);
		idle(2);
		commit_head(1'b0);
		finish_test("ignored commits");

		start_test();
		for (int i = 0; i < `SQ_DEPTH; i++) begin
			next_cycle();
			drive_store(1'b1, 1'b1, 1'b1);
		end
		idle(2);
		for (int i = 0; i < `SQ_DEPTH; i++)
			commit_head(1'b1);
		finish_test("thread 1 full");

		start_test();
		for (int i = 0; i < 5; i++) begin
			next_cycle();
			drive_store(i >= 3, 1'b1, 1'b1);
		end
		idle(2);
		load_addr   = model_q[0][0].addr;
		flushed_rob = model_q[0][0].rob_idx;
		mispredict  = 2'b01;
		idle(2);
		commit_valid   = 1'b1;		// old head of the flushed partition
		commit.thread  = 1'b0;
		commit.rob_idx = flushed_rob;
		idle(2);
		commit_head(1'b1);
		commit_head(1'b1);
		finish_test("thread 0 flush");

		start_test();
		for (int n = 0; n < 300; n++) begin
			next_cycle();
			thr = 1'(rand_bits(1));
			if (rand_bits(2) != 0 &&
					model_q[thr].size() + int'(pend_valid && pend.thread == thr) < `SQ_DEPTH)
				drive_store(thr, 1'(rand_bits(1)), 1'(rand_bits(1)));
			if (rand_bits(2) == 0)
				drive_cdb();
			thr = 1'(rand_bits(1));
			if (rand_bits(1) != 0 && !prev_commit && head_complete(thr))
				drive_commit(thr, 1'b0);
		end
		waited = 0;
		while ((model_q[0].size() > 0 || model_q[1].size() > 0 || pend_valid) &&
				waited < 400) begin
			next_cycle();
			drive_cdb();
			thr = 1'(rand_bits(1));
			if (!prev_commit && head_complete(thr))
				drive_commit(thr, 1'b0);
			waited++;
		end
		if (waited == 400)
			note_problem("random stores did not drain from the queue");
		for (int i = 0; i < `MEM_WORDS; i++) begin
			next_cycle();
			load_addr             = rand_bits(64);	// upper bits alias
			load_addr[IDX_HI:3]   = i[IDX_W-1:0];
		end
		next_cycle();
		finish_test("random traffic");

		$display("tests: %0d passed, %0d failed, %0d failed checks",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin : watchdog
		#(TEST_CYCLES * 20 * 2);
		$display("timeout: the run did not finish within %0d cycles", TEST_CYCLES * 2);
		$display("Done: errors found");
		$finish;
	end

endmodule
